/* design/bench_ctrl_defs.svh */
// Benchmark control register map
`ifndef BENCH_CTRL_DEFS_SVH
`define BENCH_CTRL_DEFS_SVH

// command registers
`define REG_IPERF           8'h00
`define REG_DDR_BENCH       8'h02

// status registers
`define REG_IPERF_CONSUMED  8'h09
`define REG_IPERF_CYCLES    8'h0C
`define REG_DDR_CYCLES      8'h0D

// index given to addresses beyond the 8-bit register space
`define REG_UNMAPPED        8'hFF

`define IPERF_WORDS         8'd4   // 128-bit command
`define DDR_WORDS           8'd8   // 193-bit command plus dest

`define REG_ADDR_SHIFT      5      // byte address to register index

`define RESP_OKAY           2'b00
`define RESP_SLVERR         2'b10

`define BAD_READ_DATA       32'hdead_beef

`endif

/* design/bench_ctrl_pkg.sv */
// Benchmark control types
`default_nettype none

package bench_ctrl_pkg;

  typedef logic [31:0]  axil_addr_t;
  typedef logic [31:0]  axil_data_t;
  typedef logic [1:0]   axil_resp_t;
  typedef logic [7:0]   reg_idx_t;
  typedef logic [7:0]   word_cnt_t;

  typedef logic [127:0] iperf_cmd_t;
  // base 47:0, size 95:48, accesses 127:96, chunk 159:128, stride 191:160, mode 192
  typedef logic [192:0] ddr_cmd_t;
  typedef logic [1:0]   ddr_dest_t;

  typedef logic [63:0]  cycles_t;
  typedef logic [47:0]  byte_cnt_t;

  typedef enum logic [1:0] {ws_idle, ws_data, ws_wait_ack, ws_response} wr_state_e;
  typedef enum logic [1:0] {as_collect, as_iperf_out, as_ddr_out} asm_state_e;
  typedef enum logic {rs_idle, rs_response} rd_state_e;

endpackage

`default_nettype wire

/* design/reg_write_if.sv */
// Decoded register write channel
`timescale 1ns/1ps
`default_nettype none

interface reg_write_if;
  logic                       wr_valid;  // one-cycle strobe per accepted word
  bench_ctrl_pkg::reg_idx_t   wr_idx;
  bench_ctrl_pkg::axil_data_t wr_data;
  logic                       wr_ack;    // write fully handled

  modport slave_side (
    output wr_valid, wr_idx, wr_data,
    input  wr_ack
  );

  modport asm_side (
    input  wr_valid, wr_idx, wr_data,
    output wr_ack
  );
endinterface

`default_nettype wire

/* design/axil_write_slave.sv */
// AXI-Lite write channel slave
`timescale 1ns/1ps
`default_nettype none
`include "bench_ctrl_defs.svh"

module axil_write_slave (
  input  wire                             user_clk,
  input  wire                             user_aresetn,
  input  wire bench_ctrl_pkg::axil_addr_t awaddr,
  input  wire                             awvalid,
  output logic                            awready,
  input  wire bench_ctrl_pkg::axil_data_t wdata,
  input  wire                             wvalid,
  output logic                            wready,
  output bench_ctrl_pkg::axil_resp_t      bresp,
  output logic                            bvalid,
  input  wire                             bready,
  reg_write_if.slave_side                 wr
);
  bench_ctrl_pkg::wr_state_e  state;
  bench_ctrl_pkg::axil_addr_t aw_word;

  assign aw_word = awaddr >> `REG_ADDR_SHIFT;
  assign bresp   = `RESP_OKAY;  // writes never fail

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      state       <= bench_ctrl_pkg::ws_idle;
      awready     <= 1'b0;
      wready      <= 1'b0;
      bvalid      <= 1'b0;
      wr.wr_valid <= 1'b0;
    end else begin
      wr.wr_valid <= 1'b0;  // strobe
      case (state)
        bench_ctrl_pkg::ws_idle: begin
          awready <= 1'b1;
          if (awvalid && awready) begin
            awready <= 1'b0;
            wready  <= 1'b1;
            state   <= bench_ctrl_pkg::ws_data;
          end
        end
        bench_ctrl_pkg::ws_data: begin
          if (wvalid && wready) begin
            wready      <= 1'b0;
            wr.wr_valid <= 1'b1;  // hand word to assembler
            state       <= bench_ctrl_pkg::ws_wait_ack;
          end
        end
        bench_ctrl_pkg::ws_wait_ack: begin
          // held here while a command waits downstream
          if (wr.wr_ack) begin
            bvalid <= 1'b1;
            state  <= bench_ctrl_pkg::ws_response;
          end
        end
        default: begin
          if (bready) begin
            bvalid  <= 1'b0;
            awready <= 1'b1;  // ready again straight away
            state   <= bench_ctrl_pkg::ws_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge user_clk) begin
    if (awvalid && awready) begin
      // addresses past the register space never hit a command register
      wr.wr_idx <= (aw_word[31:8] == '0) ? aw_word[7:0] : `REG_UNMAPPED;
    end
    if (wvalid && wready) begin
      wr.wr_data <= wdata;
    end
  end

  a_bvalid_hold: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

endmodule

`default_nettype wire

/* design/cmd_assembler.sv */
// Benchmark command assembler
`timescale 1ns/1ps
`default_nettype none
`include "bench_ctrl_defs.svh"

module cmd_assembler (
  input  wire                        user_clk,
  input  wire                        user_aresetn,
  reg_write_if.asm_side              wr,
  output logic                       iperf_cmd_valid,
  input  wire                        iperf_cmd_ready,
  output bench_ctrl_pkg::iperf_cmd_t iperf_cmd_data,
  output logic                       ddr_cmd_valid,
  input  wire                        ddr_cmd_ready,
  output bench_ctrl_pkg::ddr_cmd_t   ddr_cmd_data,
  output bench_ctrl_pkg::ddr_dest_t  ddr_cmd_dest
);
  bench_ctrl_pkg::asm_state_e state;
  bench_ctrl_pkg::word_cnt_t  word_cnt;  // shared by both command registers
  logic                       ack_owed;
  logic                       iperf_wr;
  logic                       ddr_wr;
  logic                       iperf_last;
  logic                       ddr_last;

  assign iperf_wr   = wr.wr_valid && (wr.wr_idx == `REG_IPERF);
  assign ddr_wr     = wr.wr_valid && (wr.wr_idx == `REG_DDR_BENCH);
  assign iperf_last = iperf_wr && (word_cnt == `IPERF_WORDS - 8'd1);
  assign ddr_last   = ddr_wr && (word_cnt == `DDR_WORDS - 8'd1);

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      state           <= bench_ctrl_pkg::as_collect;
      word_cnt        <= '0;
      iperf_cmd_valid <= 1'b0;
      ddr_cmd_valid   <= 1'b0;
      wr.wr_ack       <= 1'b0;
    end else begin
      wr.wr_ack <= 1'b0;
      case (state)
        bench_ctrl_pkg::as_collect: begin
          if (iperf_last) begin
            word_cnt        <= '0;
            iperf_cmd_valid <= 1'b1;
            state           <= bench_ctrl_pkg::as_iperf_out;
          end else if (ddr_last) begin
            word_cnt      <= '0;
            ddr_cmd_valid <= 1'b1;
            state         <= bench_ctrl_pkg::as_ddr_out;
          end else if (wr.wr_valid) begin
            wr.wr_ack <= 1'b1;  // nothing to wait for
            if (iperf_wr || ddr_wr) begin
              word_cnt <= word_cnt + 8'd1;
            end
          end
        end
        bench_ctrl_pkg::as_iperf_out: begin
          if (iperf_cmd_ready) begin
            iperf_cmd_valid <= 1'b0;
            wr.wr_ack       <= 1'b1;  // releases the write response
            state           <= bench_ctrl_pkg::as_collect;
          end
        end
        bench_ctrl_pkg::as_ddr_out: begin
          if (ddr_cmd_ready) begin
            ddr_cmd_valid <= 1'b0;
            wr.wr_ack     <= 1'b1;
            state         <= bench_ctrl_pkg::as_collect;
          end
        end
        default: state <= bench_ctrl_pkg::as_collect;
      endcase
    end
  end

  always_ff @(posedge user_clk) begin
    if (iperf_wr && (word_cnt < `IPERF_WORDS)) begin
      iperf_cmd_data[word_cnt[1:0] * 32 +: 32] <= wr.wr_data;
    end
    if (ddr_wr) begin
      case (word_cnt)
        8'd0: ddr_cmd_data[31:0]    <= wr.wr_data;         // base address low
        8'd1: ddr_cmd_data[47:32]   <= wr.wr_data[15:0];   // base address high
        8'd2: ddr_cmd_data[79:48]   <= wr.wr_data;         // memory size low
        8'd3: ddr_cmd_data[95:80]   <= wr.wr_data[15:0];
        8'd4: ddr_cmd_data[127:96]  <= wr.wr_data;         // access count
        8'd5: ddr_cmd_data[159:128] <= wr.wr_data;         // chunk length
        8'd6: ddr_cmd_data[191:160] <= wr.wr_data;         // stride
        8'd7: begin
          ddr_cmd_data[192] <= wr.wr_data[0];  // mode
          ddr_cmd_dest      <= wr.wr_data[2:1];
        end
        default: ;
      endcase
    end
  end

  // tracks the write slave's outstanding word
  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      ack_owed <= 1'b0;
    end else if (wr.wr_valid) begin
      ack_owed <= 1'b1;
    end else if (wr.wr_ack) begin
      ack_owed <= 1'b0;
    end
  end

  a_one_word_in_flight: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    !(wr.wr_valid && ack_owed))
    else $error("wr_valid repeated before wr_ack");

  a_iperf_stable: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    iperf_cmd_valid && !iperf_cmd_ready |=> iperf_cmd_valid && $stable(iperf_cmd_data))
    else $error("iperf command changed under back-pressure");

  a_ddr_stable: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    ddr_cmd_valid && !ddr_cmd_ready |=>
      ddr_cmd_valid && $stable({ddr_cmd_dest, ddr_cmd_data}))
    else $error("ddr command changed under back-pressure");

endmodule

`default_nettype wire

/* design/status_read_slave.sv */
// AXI-Lite status read slave
`timescale 1ns/1ps
`default_nettype none
`include "bench_ctrl_defs.svh"

module status_read_slave (
  input  wire                             user_clk,
  input  wire                             user_aresetn,
  input  wire bench_ctrl_pkg::axil_addr_t araddr,
  input  wire                             arvalid,
  output logic                            arready,
  output bench_ctrl_pkg::axil_data_t      rdata,
  output bench_ctrl_pkg::axil_resp_t      rresp,
  output logic                            rvalid,
  input  wire                             rready,
  input  wire bench_ctrl_pkg::cycles_t    iperf_execution_cycles,
  input  wire bench_ctrl_pkg::byte_cnt_t  iperf_consumed_bytes,
  input  wire bench_ctrl_pkg::cycles_t    ddr_bench_execution_cycles
);
  bench_ctrl_pkg::rd_state_e  state;
  bench_ctrl_pkg::axil_addr_t ar_word;
  bench_ctrl_pkg::reg_idx_t   ar_idx;
  bench_ctrl_pkg::reg_idx_t   rd_idx;
  bench_ctrl_pkg::reg_idx_t   cur_idx;
  bench_ctrl_pkg::axil_data_t sel_data;
  bench_ctrl_pkg::axil_resp_t sel_resp;
  logic                       iperf_upper;  // next read returns bits 63:32
  logic                       ddr_upper;

  assign ar_word = araddr >> `REG_ADDR_SHIFT;
  assign ar_idx  = (ar_word[31:8] == '0) ? ar_word[7:0] : `REG_UNMAPPED;
  // first data beat comes from the address still on the bus
  assign cur_idx = (state == bench_ctrl_pkg::rs_idle) ? ar_idx : rd_idx;

  always_comb begin
    sel_resp = `RESP_OKAY;
    case (cur_idx)
      `REG_IPERF_CONSUMED: sel_data = iperf_consumed_bytes[31:0];
      `REG_IPERF_CYCLES: begin
        sel_data = iperf_upper ? iperf_execution_cycles[63:32] : iperf_execution_cycles[31:0];
      end
      `REG_DDR_CYCLES: begin
        sel_data = ddr_upper ? ddr_bench_execution_cycles[63:32]
                             : ddr_bench_execution_cycles[31:0];
      end
      default: begin
        sel_resp = `RESP_SLVERR;
        sel_data = `BAD_READ_DATA;
      end
    endcase
  end

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      state       <= bench_ctrl_pkg::rs_idle;
      arready     <= 1'b0;
      rvalid      <= 1'b0;
      iperf_upper <= 1'b0;
      ddr_upper   <= 1'b0;
    end else begin
      case (state)
        bench_ctrl_pkg::rs_idle: begin
          arready <= 1'b1;
          if (arvalid && arready) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
            state   <= bench_ctrl_pkg::rs_response;
          end
        end
        default: begin
          if (rready) begin
            rvalid  <= 1'b0;
            arready <= 1'b1;
            state   <= bench_ctrl_pkg::rs_idle;
            if (rd_idx == `REG_IPERF_CYCLES) begin
              iperf_upper <= ~iperf_upper;
            end
            if (rd_idx == `REG_DDR_CYCLES) begin
              ddr_upper <= ~ddr_upper;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge user_clk) begin
    if (arvalid && arready) begin
      rd_idx <= ar_idx;
    end
    rdata <= sel_data;  // tracks the live counters
    rresp <= sel_resp;
  end

  a_rvalid_hold: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

endmodule

`default_nettype wire

/* design/bench_ctrl_top.sv */
// Benchmark control top level
`timescale 1ns/1ps
`default_nettype none

module bench_ctrl_top (
  input  wire                             user_clk,
  input  wire                             user_aresetn,
  // axi-lite write
  input  wire bench_ctrl_pkg::axil_addr_t s_axil_awaddr,
  input  wire                             s_axil_awvalid,
  output wire                             s_axil_awready,
  input  wire bench_ctrl_pkg::axil_data_t s_axil_wdata,
  input  wire                             s_axil_wvalid,
  output wire                             s_axil_wready,
  output wire bench_ctrl_pkg::axil_resp_t s_axil_bresp,
  output wire                             s_axil_bvalid,
  input  wire                             s_axil_bready,
  // axi-lite read
  input  wire bench_ctrl_pkg::axil_addr_t s_axil_araddr,
  input  wire                             s_axil_arvalid,
  output wire                             s_axil_arready,
  output wire bench_ctrl_pkg::axil_data_t s_axil_rdata,
  output wire bench_ctrl_pkg::axil_resp_t s_axil_rresp,
  output wire                             s_axil_rvalid,
  input  wire                             s_axil_rready,
  // commands
  output wire                             iperf_cmd_valid,
  input  wire                             iperf_cmd_ready,
  output wire bench_ctrl_pkg::iperf_cmd_t iperf_cmd_data,
  output wire                             ddr_cmd_valid,
  input  wire                             ddr_cmd_ready,
  output wire bench_ctrl_pkg::ddr_cmd_t   ddr_cmd_data,
  output wire bench_ctrl_pkg::ddr_dest_t  ddr_cmd_dest,
  // status
  input  wire bench_ctrl_pkg::cycles_t    iperf_execution_cycles,
  input  wire bench_ctrl_pkg::byte_cnt_t  iperf_consumed_bytes,
  input  wire bench_ctrl_pkg::cycles_t    ddr_bench_execution_cycles
);
  reg_write_if wr_if ();

  axil_write_slave u_write (
    .user_clk     (user_clk),
    .user_aresetn (user_aresetn),
    .awaddr       (s_axil_awaddr),
    .awvalid      (s_axil_awvalid),
    .awready      (s_axil_awready),
    .wdata        (s_axil_wdata),
    .wvalid       (s_axil_wvalid),
    .wready       (s_axil_wready),
    .bresp        (s_axil_bresp),
    .bvalid       (s_axil_bvalid),
    .bready       (s_axil_bready),
    .wr           (wr_if.slave_side)
  );

  cmd_assembler u_asm (
    .user_clk        (user_clk),
    .user_aresetn    (user_aresetn),
    .wr              (wr_if.asm_side),
    .iperf_cmd_valid (iperf_cmd_valid),
    .iperf_cmd_ready (iperf_cmd_ready),
    .iperf_cmd_data  (iperf_cmd_data),
    .ddr_cmd_valid   (ddr_cmd_valid),
    .ddr_cmd_ready   (ddr_cmd_ready),
    .ddr_cmd_data    (ddr_cmd_data),
    .ddr_cmd_dest    (ddr_cmd_dest)
  );

  status_read_slave u_read (
    .user_clk                   (user_clk),
    .user_aresetn               (user_aresetn),
    .araddr                     (s_axil_araddr),
    .arvalid                    (s_axil_arvalid),
    .arready                    (s_axil_arready),
    .rdata                      (s_axil_rdata),
    .rresp                      (s_axil_rresp),
    .rvalid                     (s_axil_rvalid),
    .rready                     (s_axil_rready),
    .iperf_execution_cycles     (iperf_execution_cycles),
    .iperf_consumed_bytes       (iperf_consumed_bytes),
    .ddr_bench_execution_cycles (ddr_bench_execution_cycles)
  );

endmodule

`default_nettype wire

/* testbench/bench_ctrl_checker.sv */
// Benchmark control port checker
`timescale 1ns/1ps
`default_nettype none
`include "bench_ctrl_defs.svh"

module bench_ctrl_checker (
  input  wire                             user_clk,
  input  wire                             user_aresetn,
  input  wire bench_ctrl_pkg::axil_addr_t awaddr,
  input  wire                             awvalid,
  input  wire                             awready,
  input  wire bench_ctrl_pkg::axil_data_t wdata,
  input  wire                             wvalid,
  input  wire                             wready,
  input  wire bench_ctrl_pkg::axil_resp_t bresp,
  input  wire                             bvalid,
  input  wire                             bready,
  input  wire bench_ctrl_pkg::axil_addr_t araddr,
  input  wire                             arvalid,
  input  wire                             arready,
  input  wire bench_ctrl_pkg::axil_data_t rdata,
  input  wire bench_ctrl_pkg::axil_resp_t rresp,
  input  wire                             rvalid,
  input  wire                             rready,
  input  wire                             iperf_cmd_valid,
  input  wire                             iperf_cmd_ready,
  input  wire bench_ctrl_pkg::iperf_cmd_t iperf_cmd_data,
  input  wire                             ddr_cmd_valid,
  input  wire                             ddr_cmd_ready,
  input  wire bench_ctrl_pkg::ddr_cmd_t   ddr_cmd_data,
  input  wire bench_ctrl_pkg::ddr_dest_t  ddr_cmd_dest,
  input  wire bench_ctrl_pkg::cycles_t    iperf_execution_cycles,
  input  wire bench_ctrl_pkg::byte_cnt_t  iperf_consumed_bytes,
  input  wire bench_ctrl_pkg::cycles_t    ddr_bench_execution_cycles,
  output int                              error_count,
  output logic                            idle
);
  bench_ctrl_pkg::axil_addr_t wr_addr;
  bench_ctrl_pkg::axil_addr_t rd_addr;
  bench_ctrl_pkg::axil_addr_t word;
  int                         word_cnt;       // model of the shared counter
  int                         writes_open;
  int                         reads_open;
  bench_ctrl_pkg::iperf_cmd_t iperf_exp;
  bench_ctrl_pkg::ddr_cmd_t   ddr_exp;
  logic [47:0]                base;
  logic [47:0]                size;
  logic [31:0]                count;
  logic [31:0]                chunk;
  logic [31:0]                stride;
  logic                       mode;
  bench_ctrl_pkg::ddr_dest_t  dest;
  logic                       iperf_due;      // all words seen, command expected
  logic                       ddr_due;
  logic                       iperf_half;     // next read gives upper half
  logic                       ddr_half;
  logic                       iperf_held;
  logic                       ddr_held;
  bench_ctrl_pkg::iperf_cmd_t iperf_prev;
  logic [194:0]               ddr_prev;
  bench_ctrl_pkg::axil_data_t exp_data;
  bench_ctrl_pkg::axil_resp_t exp_resp;
  logic                       rst_seen = 1'b0;

  initial error_count = 0;

  assign idle = !iperf_due && !ddr_due && (writes_open == 0) && (reads_open == 0);

  task automatic report_mismatch(input string name, input string exp, input string got);
    $display("FAIL t=%0t signal=%s expected=%s got=%s", $time, name, exp, got);
    error_count++;
  endtask

  task automatic report_protocol(input string what);
    $display("ERROR t=%0t %s", $time, what);
    error_count++;
  endtask

  always @(posedge user_clk) begin
    if (!user_aresetn) begin
      if (rst_seen && ((awready | wready | bvalid | arready | rvalid |
                        iperf_cmd_valid | ddr_cmd_valid) !== 1'b0)) begin
        report_protocol("a handshake output is not low during reset");
      end
      rst_seen    = 1'b1;
      word_cnt    = 0;
      writes_open = 0;
      reads_open  = 0;
      iperf_due   = 1'b0;
      ddr_due     = 1'b0;
      iperf_half  = 1'b0;
      ddr_half    = 1'b0;
      iperf_held  = 1'b0;
      ddr_held    = 1'b0;
    end else begin
      // command side
      if (iperf_cmd_valid === 1'b1 && !iperf_due) begin
        report_protocol("iperf command offered before all four words were written");
      end
      if (ddr_cmd_valid === 1'b1 && !ddr_due) begin
        report_protocol("ddr command offered before all eight words were written");
      end
      if (iperf_held && (iperf_cmd_valid !== 1'b1 || iperf_cmd_data !== iperf_prev)) begin
        report_protocol("iperf command dropped or changed while ready was low");
      end
      if (ddr_held && (ddr_cmd_valid !== 1'b1 || {ddr_cmd_dest, ddr_cmd_data} !== ddr_prev)) begin
        report_protocol("ddr command dropped or changed while ready was low");
      end
      iperf_held = iperf_cmd_valid && !iperf_cmd_ready;
      ddr_held   = ddr_cmd_valid && !ddr_cmd_ready;
      iperf_prev = iperf_cmd_data;
      ddr_prev   = {ddr_cmd_dest, ddr_cmd_data};

      // response must wait for the command handshake
      if (bvalid === 1'b1 && (iperf_due || ddr_due)) begin
        report_protocol("write response given before the command was accepted");
      end
      if (iperf_cmd_valid && iperf_cmd_ready && iperf_due) begin
        if (iperf_cmd_data !== iperf_exp) begin
          report_mismatch("iperf_cmd_data", $sformatf("%h", iperf_exp),
                          $sformatf("%h", iperf_cmd_data));
        end
        iperf_due = 1'b0;
      end
      if (ddr_cmd_valid && ddr_cmd_ready && ddr_due) begin
        ddr_exp = {mode, stride, chunk, count, size, base};
        if (ddr_cmd_data !== ddr_exp) begin
          report_mismatch("ddr_cmd_data", $sformatf("%h", ddr_exp),
                          $sformatf("%h", ddr_cmd_data));
        end
        if (ddr_cmd_dest !== dest) begin
          report_mismatch("ddr_cmd_dest", $sformatf("%h", dest), $sformatf("%h", ddr_cmd_dest));
        end
        ddr_due = 1'b0;
      end

      // write channel
      if (bvalid && bready) begin
        if (writes_open == 0) begin
          report_protocol("write response with no write outstanding");
        end else begin
          writes_open--;
        end
        if (bresp !== `RESP_OKAY) begin
          report_mismatch("bresp", $sformatf("%h", `RESP_OKAY), $sformatf("%h", bresp));
        end
      end
      if (awvalid && awready) begin
        wr_addr = awaddr;
      end
      if (wvalid && wready) begin
        writes_open++;
        word = wr_addr >> `REG_ADDR_SHIFT;
        if (word == {24'd0, `REG_IPERF}) begin
          if (word_cnt < 4) begin
            iperf_exp[32 * word_cnt +: 32] = wdata;
          end
          if (word_cnt == 3) begin
            iperf_due = 1'b1;
            word_cnt  = 0;
          end else begin
            word_cnt++;
          end
        end else if (word == {24'd0, `REG_DDR_BENCH}) begin
          case (word_cnt)
            0: base[31:0]   = wdata;
            1: base[47:32]  = wdata[15:0];  // only the low half counts
            2: size[31:0]   = wdata;
            3: size[47:32]  = wdata[15:0];
            4: count        = wdata;
            5: chunk        = wdata;
            6: stride       = wdata;
            7: begin
              mode = wdata[0];
              dest = wdata[2:1];
            end
            default: ;
          endcase
          if (word_cnt == 7) begin
            ddr_due  = 1'b1;
            word_cnt = 0;
          end else begin
            word_cnt++;
          end
        end
      end

      // read channel
      if (rvalid && rready) begin
        if (reads_open == 0) begin
          report_protocol("read data with no read outstanding");
        end else begin
          reads_open--;
        end
        word     = rd_addr >> `REG_ADDR_SHIFT;
        exp_resp = `RESP_OKAY;
        if (word == {24'd0, `REG_IPERF_CONSUMED}) begin
          exp_data = iperf_consumed_bytes[31:0];
        end else if (word == {24'd0, `REG_IPERF_CYCLES}) begin
          exp_data   = iperf_half ? iperf_execution_cycles[63:32] : iperf_execution_cycles[31:0];
          iperf_half = !iperf_half;
        end else if (word == {24'd0, `REG_DDR_CYCLES}) begin
          exp_data = ddr_half ? ddr_bench_execution_cycles[63:32]
                              : ddr_bench_execution_cycles[31:0];
          ddr_half = !ddr_half;
        end else begin
          exp_data = `BAD_READ_DATA;
          exp_resp = `RESP_SLVERR;
        end
        if (rdata !== exp_data) begin
          report_mismatch("rdata", $sformatf("%h", exp_data), $sformatf("%h", rdata));
        end
        if (rresp !== exp_resp) begin
          report_mismatch("rresp", $sformatf("%h", exp_resp), $sformatf("%h", rresp));
        end
      end
      if (arvalid && arready) begin
        rd_addr = araddr;
        reads_open++;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_bench_ctrl.sv */
// Benchmark control testbench
`timescale 1ns/1ps
`default_nettype none
`include "bench_ctrl_defs.svh"

module tb_bench_ctrl;
  localparam int N_OPS        = 60;
  localparam int TXN_PER_OP   = 8;   // a ddr command is the longest op
  localparam int WATCHDOG_NS  = N_OPS * TXN_PER_OP * 200 * 10;

  logic                       user_clk;
  logic                       user_aresetn;
  bench_ctrl_pkg::axil_addr_t s_axil_awaddr;
  logic                       s_axil_awvalid;
  wire                        s_axil_awready;
  bench_ctrl_pkg::axil_data_t s_axil_wdata;
  logic                       s_axil_wvalid;
  wire                        s_axil_wready;
  bench_ctrl_pkg::axil_resp_t s_axil_bresp;
  wire                        s_axil_bvalid;
  logic                       s_axil_bready;
  bench_ctrl_pkg::axil_addr_t s_axil_araddr;
  logic                       s_axil_arvalid;
  wire                        s_axil_arready;
  bench_ctrl_pkg::axil_data_t s_axil_rdata;
  bench_ctrl_pkg::axil_resp_t s_axil_rresp;
  wire                        s_axil_rvalid;
  logic                       s_axil_rready;
  wire                        iperf_cmd_valid;
  logic                       iperf_cmd_ready;
  bench_ctrl_pkg::iperf_cmd_t iperf_cmd_data;
  wire                        ddr_cmd_valid;
  logic                       ddr_cmd_ready;
  bench_ctrl_pkg::ddr_cmd_t   ddr_cmd_data;
  bench_ctrl_pkg::ddr_dest_t  ddr_cmd_dest;
  bench_ctrl_pkg::cycles_t    iperf_execution_cycles;
  bench_ctrl_pkg::byte_cnt_t  iperf_consumed_bytes;
  bench_ctrl_pkg::cycles_t    ddr_bench_execution_cycles;

  integer seed       = 32'h2b30_e2a6;
  integer stall_seed;  // separate stream for command ready
  int     tb_errors  = 0;
  int     chk_errors;
  logic   chk_idle;
  int     op;
  bench_ctrl_pkg::axil_addr_t r;

  bench_ctrl_top u_dut (.*);

  bench_ctrl_checker u_chk (
    .user_clk (user_clk), .user_aresetn (user_aresetn),
    .awaddr (s_axil_awaddr), .awvalid (s_axil_awvalid), .awready (s_axil_awready),
    .wdata (s_axil_wdata), .wvalid (s_axil_wvalid), .wready (s_axil_wready),
    .bresp (s_axil_bresp), .bvalid (s_axil_bvalid), .bready (s_axil_bready),
    .araddr (s_axil_araddr), .arvalid (s_axil_arvalid), .arready (s_axil_arready),
    .rdata (s_axil_rdata), .rresp (s_axil_rresp), .rvalid (s_axil_rvalid),
    .rready (s_axil_rready),
    .iperf_cmd_valid (iperf_cmd_valid), .iperf_cmd_ready (iperf_cmd_ready),
    .iperf_cmd_data (iperf_cmd_data),
    .ddr_cmd_valid (ddr_cmd_valid), .ddr_cmd_ready (ddr_cmd_ready),
    .ddr_cmd_data (ddr_cmd_data), .ddr_cmd_dest (ddr_cmd_dest),
    .iperf_execution_cycles (iperf_execution_cycles),
    .iperf_consumed_bytes (iperf_consumed_bytes),
    .ddr_bench_execution_cycles (ddr_bench_execution_cycles),
    .error_count (chk_errors), .idle (chk_idle)
  );

  always #5 user_clk = ~user_clk;

  // mostly stalled downstream back-pressure
  always @(posedge user_clk) begin
    #1;
    iperf_cmd_ready = (($random(stall_seed) & 7) == 0);
    ddr_cmd_ready   = (($random(stall_seed) & 7) == 0);
  end

  // entered and left 1 ns after a rising edge
  task automatic axil_write(input bench_ctrl_pkg::axil_addr_t addr,
                            input bench_ctrl_pkg::axil_data_t data);
    logic hs;
    s_axil_awaddr  = addr;
    s_axil_awvalid = 1'b1;
    hs = 1'b0;
    while (!hs) begin
      hs = s_axil_awready;  // stable until the next edge
      @(posedge user_clk);
      #1;
    end
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = data;
    s_axil_wvalid  = 1'b1;
    hs = 1'b0;
    while (!hs) begin
      hs = s_axil_wready;
      @(posedge user_clk);
      #1;
    end
    s_axil_wvalid = 1'b0;
    hs = 1'b0;
    while (!hs) begin
      s_axil_bready = (($random(seed) & 3) != 0);
      hs = s_axil_bvalid && s_axil_bready;
      @(posedge user_clk);
      #1;
    end
    s_axil_bready = 1'b0;
  endtask

  task automatic axil_read(input bench_ctrl_pkg::axil_addr_t addr);
    logic        hs;
    logic [63:0] r64;
    // status moves only while no read is open
    iperf_execution_cycles     = {$random(seed), $random(seed)};
    ddr_bench_execution_cycles = {$random(seed), $random(seed)};
    r64 = {$random(seed), $random(seed)};
    iperf_consumed_bytes = r64[47:0];
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    hs = 1'b0;
    while (!hs) begin
      hs = s_axil_arready;
      @(posedge user_clk);
      #1;
    end
    s_axil_arvalid = 1'b0;
    hs = 1'b0;
    while (!hs) begin
      s_axil_rready = (($random(seed) & 3) != 0);
      hs = s_axil_rvalid && s_axil_rready;
      @(posedge user_clk);
      #1;
    end
    s_axil_rready = 1'b0;
  endtask

  initial begin
    stall_seed = $random(seed);
    user_clk = 1'b0;
    user_aresetn = 1'b0;
    s_axil_awaddr = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata = '0;
    s_axil_wvalid = 1'b0;
    s_axil_bready = 1'b0;
    s_axil_araddr = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready = 1'b0;
    iperf_cmd_ready = 1'b0;
    ddr_cmd_ready = 1'b0;
    iperf_execution_cycles = '0;
    iperf_consumed_bytes = '0;
    ddr_bench_execution_cycles = '0;
    repeat (3) @(posedge user_clk);
    #1;
    user_aresetn = 1'b1;
    for (int i = 0; i < N_OPS; i++) begin
      op = {$random(seed)} % 6;
      r  = $random(seed);
      case (op)
        0: begin
          for (int k = 0; k < 4; k++) begin
            axil_write({19'd0, `REG_IPERF, r[4:0]}, $random(seed));
          end
        end
        1: begin
          for (int k = 0; k < 8; k++) begin
            axil_write({19'd0, `REG_DDR_BENCH, r[4:0]}, $random(seed));
          end
        end
        2: begin
          if (r[0]) r = r & 32'h1fff;  // keep inside the register space
          if ((r >> `REG_ADDR_SHIFT) == {24'd0, `REG_IPERF} ||
              (r >> `REG_ADDR_SHIFT) == {24'd0, `REG_DDR_BENCH}) begin
            r = {19'd0, 8'h01, 5'd0};
          end
          axil_write(r, $random(seed));
        end
        3: axil_read({19'd0, `REG_IPERF_CYCLES, r[4:0]});
        4: axil_read({19'd0, `REG_DDR_CYCLES, r[4:0]});
        default: begin
          if (r[1]) begin
            axil_read({19'd0, `REG_IPERF_CONSUMED, r[4:0]});
          end else begin
            if (r[0]) r = r & 32'h1fff;
            if ((r >> `REG_ADDR_SHIFT) == {24'd0, `REG_IPERF_CONSUMED} ||
                (r >> `REG_ADDR_SHIFT) == {24'd0, `REG_IPERF_CYCLES} ||
                (r >> `REG_ADDR_SHIFT) == {24'd0, `REG_DDR_CYCLES}) begin
              r = {19'd0, 8'h03, 5'd0};
            end
            axil_read(r);
          end
        end
      endcase
    end
    repeat (5) @(posedge user_clk);
    if (chk_idle !== 1'b1) begin
      $display("ERROR: a command or response was still missing at the end of the run");
      tb_errors++;
    end
    $display("error count: checker %0d, testbench %0d", chk_errors, tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired, a handshake never completed");
    $display("error count: checker %0d, testbench %0d", chk_errors, tb_errors + 1);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* bench_ctrl.f */
+incdir+design
design/bench_ctrl_pkg.sv
design/reg_write_if.sv
design/axil_write_slave.sv
design/cmd_assembler.sv
design/status_read_slave.sv
design/bench_ctrl_top.sv
testbench/bench_ctrl_checker.sv
testbench/tb_bench_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and decide on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --timescale 1ns/1ps --top-module tb_bench_ctrl \
  -f bench_ctrl.f -o sim_bench_ctrl || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_bench_ctrl)
echo "$out"
echo "$out" | grep -qx "Finished with no errors" && echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
